// ==== hw/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

	localparam int DELAY_MS_W = 8;
	localparam int STEP_W = 6;
	localparam int PRESCALE_W = 14;
	localparam int RST_CNT_W = 12;
	localparam int WR_CNT_W = 2;

	typedef logic [15:0] lcd_word_t;
	typedef logic [7:0] lcd_reg_t;

	localparam logic [PRESCALE_W-1:0] CYCLES_PER_MS = 14'd10000; // 10 MHz clock
	localparam logic [RST_CNT_W-1:0] RST_LOW_CYCLES = 12'd200;
	localparam logic [RST_CNT_W-1:0] RST_WAIT_CYCLES = 12'd2000;
	localparam logic [WR_CNT_W-1:0] WR_SETUP_CYCLES = 2'd2;
	localparam logic [WR_CNT_W-1:0] WR_LOW_CYCLES = 2'd2;
	localparam logic [WR_CNT_W-1:0] WR_HOLD_CYCLES = 2'd2;
	localparam logic [STEP_W-1:0] INIT_LEN = 6'd51; // End entry included

	typedef enum logic [1:0] {
		INIT_REG_WRITE = 2'd0,
		INIT_DELAY = 2'd1,
		INIT_END = 2'd2
	} init_op_e;

	typedef enum logic [7:0] {
		REG_DISPLAY_MODE = 8'h01,
		REG_COL_START_1 = 8'h02,
		REG_COL_START_2 = 8'h03,
		REG_COL_END_1 = 8'h04,
		REG_COL_END_2 = 8'h05,
		REG_ROW_START_1 = 8'h06,
		REG_ROW_START_2 = 8'h07,
		REG_ROW_END_1 = 8'h08,
		REG_ROW_END_2 = 8'h09,
		REG_MEMORY_ACCESS_CONTROL = 8'h16,
		REG_OSC_CONTROL_1 = 8'h17,
		REG_POWER_CONTROL_1 = 8'h19,
		REG_POWER_CONTROL_2 = 8'h1a,
		REG_POWER_CONTROL_3 = 8'h1b,
		REG_POWER_CONTROL_4 = 8'h1c,
		REG_POWER_CONTROL_6 = 8'h1e,
		REG_VCOM_CONTROL = 8'h1f,
		REG_DATA_READ_WRITE = 8'h22, // GRAM write port
		REG_DISPLAY_CONTROL_2 = 8'h24,
		REG_CYCLE_CONTROL_1 = 8'h2b,
		REG_CYCLE_CONTROL_10 = 8'h34,
		REG_CYCLE_CONTROL_11 = 8'h35,
		REG_SOURCE_CONTROL_2 = 8'h3d,
		REG_GAMMA_CONTROL_1 = 8'h3e,
		REG_GAMMA_CONTROL_2 = 8'h3f,
		REG_GAMMA_CONTROL_3 = 8'h40,
		REG_GAMMA_CONTROL_5 = 8'h42,
		REG_GAMMA_CONTROL_6 = 8'h43,
		REG_GAMMA_CONTROL_7 = 8'h44,
		REG_GAMMA_CONTROL_8 = 8'h45,
		REG_GAMMA_CONTROL_9 = 8'h46,
		REG_GAMMA_CONTROL_10 = 8'h47,
		REG_GAMMA_CONTROL_11 = 8'h48,
		REG_GAMMA_CONTROL_12 = 8'h49,
		REG_PANEL_CONTROL = 8'h55,
		REG_TEST_MODE = 8'h83,
		REG_VDDD_CONTROL = 8'h85,
		REG_VGS_RES_CONTROL_1 = 8'h8b,
		REG_VGS_RES_CONTROL_2 = 8'h8c,
		REG_PWM_CONTROL_0 = 8'h91
	} lcd_reg_e;

	typedef enum logic [2:0] {
		SEQ_WAIT_RESET,
		SEQ_INIT_ISSUE,
		SEQ_INIT_DELAY,
		SEQ_IDLE,
		SEQ_SEND_REG,
		SEQ_SEND_DATA,
		SEQ_HOST_ACK
	} seq_state_e;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_SETUP,
		PH_STROBE,
		PH_HOLD,
		PH_DONE
	} wr_phase_e;

endpackage

`default_nettype wire

// ==== hw/lcd_write_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface lcd_write_if;

	logic req;
	logic rs; // 0 register address, 1 data
	lcd_pkg::lcd_word_t word;
	logic ack;

	modport seq (output req, output rs, output word, input ack);

	modport bus (input req, input rs, input word, output ack);

endinterface

`default_nettype wire

// ==== hw/lcd_reset_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_reset_gen (
	input wire init_commands_clk,
	input wire init_commands_reset,
	output logic lcd_rst,
	output logic panel_ready
);

	logic [lcd_pkg::RST_CNT_W-1:0] rst_cnt;

	// Low phase then recovery phase on one counter
	always_ff @(posedge init_commands_clk or posedge init_commands_reset) begin
		if (init_commands_reset) begin
			rst_cnt <= '0;
			lcd_rst <= 1'b0;
			panel_ready <= 1'b0;
		end else if (!panel_ready) begin
			rst_cnt <= rst_cnt + 1'b1;
			if (rst_cnt == lcd_pkg::RST_LOW_CYCLES - 1'b1) begin
				lcd_rst <= 1'b1; // Release panel reset
			end
			if (rst_cnt == lcd_pkg::RST_LOW_CYCLES + lcd_pkg::RST_WAIT_CYCLES - 1'b1) begin
				panel_ready <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/lcd_delay_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_delay_timer (
	input wire init_commands_clk,
	input wire init_commands_reset,
	input wire delay_start,
	input wire [lcd_pkg::DELAY_MS_W-1:0] delay_ms,
	output logic delay_done
);

	logic [lcd_pkg::PRESCALE_W-1:0] pre_cnt;
	logic [lcd_pkg::DELAY_MS_W-1:0] ms_cnt;
	logic busy;
	logic ms_tick;

	assign ms_tick = busy && (pre_cnt == lcd_pkg::CYCLES_PER_MS - 1'b1);

	always_ff @(posedge init_commands_clk or posedge init_commands_reset) begin
		if (init_commands_reset) begin
			pre_cnt <= '0;
			ms_cnt <= '0;
			busy <= 1'b0;
			delay_done <= 1'b0;
		end else begin
			delay_done <= 1'b0;
			if (delay_start) begin
				busy <= 1'b1;
				pre_cnt <= '0;
				ms_cnt <= delay_ms;
			end else if (ms_tick) begin
				pre_cnt <= '0;
				ms_cnt <= ms_cnt - 1'b1;
				if (ms_cnt <= 8'd1) begin // Last millisecond
					busy <= 1'b0;
					delay_done <= 1'b1;
				end
			end else if (busy) begin
				pre_cnt <= pre_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/lcd_init_rom.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_init_rom (
	input wire [lcd_pkg::STEP_W-1:0] step,
	output lcd_pkg::init_op_e op,
	output lcd_pkg::lcd_reg_t reg_addr,
	output logic [7:0] value
);

	logic [17:0] entry; // Opcode, register, value or milliseconds

	assign op = lcd_pkg::init_op_e'(entry[17:16]);
	assign reg_addr = entry[15:8];
	assign value = entry[7:0];

	always_comb begin
		case (step)
			6'd0: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_TEST_MODE, 8'h02};
			6'd1: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_VDDD_CONTROL, 8'h03};
			6'd2: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_VGS_RES_CONTROL_1, 8'h01};
			6'd3: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_VGS_RES_CONTROL_2, 8'h93};
			6'd4: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_PWM_CONTROL_0, 8'h01};
			6'd5: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_TEST_MODE, 8'h00};
			6'd6: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_GAMMA_CONTROL_1, 8'hb0}; // Gamma
			6'd7: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_GAMMA_CONTROL_2, 8'h03};
			6'd8: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_GAMMA_CONTROL_3, 8'h10};
			6'd9: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_GAMMA_CONTROL_5, 8'h13};
			6'd10: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_GAMMA_CONTROL_6, 8'h46};
			6'd11: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_GAMMA_CONTROL_7, 8'h23};
			6'd12: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_GAMMA_CONTROL_8, 8'h76};
			6'd13: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_GAMMA_CONTROL_9, 8'h00};
			6'd14: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_GAMMA_CONTROL_10, 8'h5e};
			6'd15: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_GAMMA_CONTROL_11, 8'h4f};
			6'd16: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_GAMMA_CONTROL_12, 8'h40};
			6'd17: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_OSC_CONTROL_1, 8'h91}; // Power on
			6'd18: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_CYCLE_CONTROL_1, 8'hf9};
			6'd19: entry = {lcd_pkg::INIT_DELAY, 8'h00, 8'd10};
			6'd20: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_POWER_CONTROL_3, 8'h14};
			6'd21: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_POWER_CONTROL_2, 8'h11};
			6'd22: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_POWER_CONTROL_4, 8'h06};
			6'd23: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_VCOM_CONTROL, 8'h42};
			6'd24: entry = {lcd_pkg::INIT_DELAY, 8'h00, 8'd20};
			6'd25: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_POWER_CONTROL_1, 8'h0a};
			6'd26: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_POWER_CONTROL_1, 8'h1a};
			6'd27: entry = {lcd_pkg::INIT_DELAY, 8'h00, 8'd40};
			6'd28: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_POWER_CONTROL_1, 8'h12};
			6'd29: entry = {lcd_pkg::INIT_DELAY, 8'h00, 8'd40};
			6'd30: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_POWER_CONTROL_6, 8'h27};
			6'd31: entry = {lcd_pkg::INIT_DELAY, 8'h00, 8'd100};
			6'd32: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_DISPLAY_CONTROL_2, 8'h60}; // Display on
			6'd33: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_SOURCE_CONTROL_2, 8'h40};
			6'd34: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_CYCLE_CONTROL_10, 8'h38};
			6'd35: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_CYCLE_CONTROL_11, 8'h38};
			6'd36: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_DISPLAY_CONTROL_2, 8'h38};
			6'd37: entry = {lcd_pkg::INIT_DELAY, 8'h00, 8'd40};
			6'd38: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_DISPLAY_CONTROL_2, 8'h3c};
			6'd39: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_MEMORY_ACCESS_CONTROL, 8'h1c};
			6'd40: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_DISPLAY_MODE, 8'h06};
			6'd41: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_PANEL_CONTROL, 8'h00};
			6'd42: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_COL_START_1, 8'h00}; // Window 240x400
			6'd43: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_COL_START_2, 8'h00};
			6'd44: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_COL_END_1, 8'h00};
			6'd45: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_COL_END_2, 8'hef};
			6'd46: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_ROW_START_1, 8'h00};
			6'd47: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_ROW_START_2, 8'h00};
			6'd48: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_ROW_END_1, 8'h01};
			6'd49: entry = {lcd_pkg::INIT_REG_WRITE, lcd_pkg::REG_ROW_END_2, 8'h8f};
			default: entry = {lcd_pkg::INIT_END, 8'h00, 8'h00};
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/lcd_bus_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_bus_writer (
	input wire init_commands_clk,
	input wire init_commands_reset,
	lcd_write_if.bus wr,
	output logic lcd_cs,
	output logic lcd_rs,
	output logic lcd_wr,
	output lcd_pkg::lcd_word_t lcd_db
);

	lcd_pkg::wr_phase_e phase;
	logic [lcd_pkg::WR_CNT_W-1:0] phase_cnt;

	always_ff @(posedge init_commands_clk or posedge init_commands_reset) begin
		if (init_commands_reset) begin
			phase <= lcd_pkg::PH_IDLE;
			phase_cnt <= '0;
			lcd_cs <= 1'b1;
			lcd_rs <= 1'b0;
			lcd_wr <= 1'b1;
			lcd_db <= '0;
			wr.ack <= 1'b0;
		end else begin
			case (phase)
				lcd_pkg::PH_IDLE: begin
					if (wr.req) begin
						phase <= lcd_pkg::PH_SETUP;
						phase_cnt <= lcd_pkg::WR_SETUP_CYCLES - 1'b1;
						lcd_cs <= 1'b0;
						lcd_rs <= wr.rs;
						lcd_db <= wr.word;
					end
				end
				lcd_pkg::PH_SETUP: begin
					if (phase_cnt == '0) begin
						phase <= lcd_pkg::PH_STROBE;
						phase_cnt <= lcd_pkg::WR_LOW_CYCLES - 1'b1;
						lcd_wr <= 1'b0;
					end else begin
						phase_cnt <= phase_cnt - 1'b1;
					end
				end
				lcd_pkg::PH_STROBE: begin
					if (phase_cnt == '0) begin
						phase <= lcd_pkg::PH_HOLD;
						phase_cnt <= lcd_pkg::WR_HOLD_CYCLES - 1'b1;
						lcd_wr <= 1'b1; // Panel latches data here
					end else begin
						phase_cnt <= phase_cnt - 1'b1;
					end
				end
				lcd_pkg::PH_HOLD: begin
					if (phase_cnt == '0) begin
						phase <= lcd_pkg::PH_DONE;
						lcd_cs <= 1'b1;
						wr.ack <= 1'b1;
					end else begin
						phase_cnt <= phase_cnt - 1'b1;
					end
				end
				lcd_pkg::PH_DONE: begin
					if (!wr.req) begin
						phase <= lcd_pkg::PH_IDLE;
						wr.ack <= 1'b0;
					end
				end
				default: phase <= lcd_pkg::PH_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/lcd_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_sequencer (
	input wire init_commands_clk,
	input wire init_commands_reset,
	input wire panel_ready,
	input wire host_req,
	input wire host_is_cmd,
	input wire lcd_pkg::lcd_reg_t host_reg,
	input wire lcd_pkg::lcd_word_t host_data,
	output logic host_ack,
	output logic init_done,
	output logic [lcd_pkg::STEP_W-1:0] step,
	input wire lcd_pkg::init_op_e op,
	input wire lcd_pkg::lcd_reg_t reg_addr,
	input wire [7:0] value,
	output logic delay_start,
	output logic [lcd_pkg::DELAY_MS_W-1:0] delay_ms,
	input wire delay_done,
	lcd_write_if.seq wr
);

	lcd_pkg::seq_state_e state;
	lcd_pkg::lcd_word_t data_q;
	logic [lcd_pkg::STEP_W-1:0] step_next;
	logic load_init;
	logic load_host;
	logic word_done;

	// Step stays on the end entry
	assign step_next = (step == lcd_pkg::INIT_LEN - 1'b1) ? step : step + 1'b1;
	assign load_init = (state == lcd_pkg::SEQ_INIT_ISSUE) && (op == lcd_pkg::INIT_REG_WRITE);
	assign load_host = (state == lcd_pkg::SEQ_IDLE) && host_req;
	assign word_done = !wr.req && !wr.ack;

	always_ff @(posedge init_commands_clk) begin
		if (load_init) begin
			data_q <= {8'h00, value};
		end else if (load_host) begin
			data_q <= host_data;
		end
	end

	always_ff @(posedge init_commands_clk or posedge init_commands_reset) begin
		if (init_commands_reset) begin
			state <= lcd_pkg::SEQ_WAIT_RESET;
			step <= '0;
			host_ack <= 1'b0;
			init_done <= 1'b0;
			delay_start <= 1'b0;
			delay_ms <= '0;
			wr.req <= 1'b0;
			wr.rs <= 1'b0;
			wr.word <= '0;
		end else begin
			delay_start <= 1'b0;
			case (state)
				lcd_pkg::SEQ_WAIT_RESET: begin
					if (panel_ready) begin
						state <= lcd_pkg::SEQ_INIT_ISSUE;
					end
				end
				lcd_pkg::SEQ_INIT_ISSUE: begin
					case (op)
						lcd_pkg::INIT_REG_WRITE: begin
							wr.req <= 1'b1;
							wr.rs <= 1'b0;
							wr.word <= {8'h00, reg_addr};
							state <= lcd_pkg::SEQ_SEND_REG;
						end
						lcd_pkg::INIT_DELAY: begin
							delay_start <= 1'b1;
							delay_ms <= value; // Milliseconds in value field
							state <= lcd_pkg::SEQ_INIT_DELAY;
						end
						default: begin
							init_done <= 1'b1;
							state <= lcd_pkg::SEQ_IDLE;
						end
					endcase
				end
				lcd_pkg::SEQ_INIT_DELAY: begin
					if (delay_done) begin
						step <= step_next;
						state <= lcd_pkg::SEQ_INIT_ISSUE;
					end
				end
				lcd_pkg::SEQ_IDLE: begin
					if (host_req) begin
						wr.req <= 1'b1;
						wr.rs <= 1'b0;
						wr.word <= {8'h00, host_is_cmd ? host_reg : lcd_pkg::REG_DATA_READ_WRITE};
						state <= lcd_pkg::SEQ_SEND_REG;
					end
				end
				lcd_pkg::SEQ_SEND_REG: begin
					if (wr.req && wr.ack) begin
						wr.req <= 1'b0;
					end else if (word_done) begin
						wr.req <= 1'b1;
						wr.rs <= 1'b1;
						wr.word <= data_q;
						state <= lcd_pkg::SEQ_SEND_DATA;
					end
				end
				lcd_pkg::SEQ_SEND_DATA: begin
					if (wr.req && wr.ack) begin
						wr.req <= 1'b0;
					end else if (word_done && init_done) begin
						host_ack <= 1'b1;
						state <= lcd_pkg::SEQ_HOST_ACK;
					end else if (word_done) begin
						step <= step_next;
						state <= lcd_pkg::SEQ_INIT_ISSUE;
					end
				end
				lcd_pkg::SEQ_HOST_ACK: begin
					if (!host_req) begin
						host_ack <= 1'b0;
						state <= lcd_pkg::SEQ_IDLE;
					end
				end
				default: state <= lcd_pkg::SEQ_WAIT_RESET;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/hx8352_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module hx8352_controller (
	input wire init_commands_clk,
	input wire init_commands_reset,
	input wire host_req,
	input wire host_is_cmd,
	input wire lcd_pkg::lcd_reg_t host_reg,
	input wire lcd_pkg::lcd_word_t host_data,
	output logic host_ack,
	output logic init_done,
	output logic lcd_rst,
	output logic lcd_cs,
	output logic lcd_rs,
	output logic lcd_wr,
	output lcd_pkg::lcd_word_t lcd_db
);

	logic panel_ready;
	logic delay_start;
	logic delay_done;
	logic [lcd_pkg::DELAY_MS_W-1:0] delay_ms;
	logic [lcd_pkg::STEP_W-1:0] step;
	lcd_pkg::init_op_e op;
	lcd_pkg::lcd_reg_t reg_addr;
	logic [7:0] value;

	lcd_write_if wr_if ();

	lcd_reset_gen lcd_reset_gen_i (
		.init_commands_clk(init_commands_clk),
		.init_commands_reset(init_commands_reset),
		.lcd_rst(lcd_rst),
		.panel_ready(panel_ready)
	);

	lcd_delay_timer lcd_delay_timer_i (
		.init_commands_clk(init_commands_clk),
		.init_commands_reset(init_commands_reset),
		.delay_start(delay_start),
		.delay_ms(delay_ms),
		.delay_done(delay_done)
	);

	lcd_init_rom lcd_init_rom_i (
		.step(step),
		.op(op),
		.reg_addr(reg_addr),
		.value(value)
	);

	lcd_sequencer lcd_sequencer_i (
		.init_commands_clk(init_commands_clk),
		.init_commands_reset(init_commands_reset),
		.panel_ready(panel_ready),
		.host_req(host_req),
		.host_is_cmd(host_is_cmd),
		.host_reg(host_reg),
		.host_data(host_data),
		.host_ack(host_ack),
		.init_done(init_done),
		.step(step),
		.op(op),
		.reg_addr(reg_addr),
		.value(value),
		.delay_start(delay_start),
		.delay_ms(delay_ms),
		.delay_done(delay_done),
		.wr(wr_if.seq)
	);

	lcd_bus_writer lcd_bus_writer_i (
		.init_commands_clk(init_commands_clk),
		.init_commands_reset(init_commands_reset),
		.wr(wr_if.bus),
		.lcd_cs(lcd_cs),
		.lcd_rs(lcd_rs),
		.lcd_wr(lcd_wr),
		.lcd_db(lcd_db)
	);

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic init_commands_clk,
	output logic init_commands_reset
);

	localparam int HALF_PERIOD = 50; // 100 ns period
	localparam int RESET_CYCLES = 10;

	initial begin
		init_commands_clk = 1'b0;
		forever #HALF_PERIOD init_commands_clk = ~init_commands_clk;
	end

	initial begin
		init_commands_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge init_commands_clk);
		@(negedge init_commands_clk);
		init_commands_reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== sim/hx8352_controller_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module hx8352_controller_tb;

	localparam int INIT_WORDS = 88;
	localparam int TABLE_LEN = 50;
	localparam int CYCLES_PER_MS = 10000;
	localparam int RST_WAIT_CYCLES = 2000;
	localparam int INIT_TIMEOUT = 3000000; // Whole power-on list
	localparam int XFER_TIMEOUT = 200;
	localparam int HOLD_CYCLES = 8;
	localparam logic [7:0] PIXEL_REG = 8'h22;

	// Upper byte 00 marks a delay of lower byte ms
	localparam logic [15:0] POWER_ON_TABLE [TABLE_LEN] = '{
		16'h8302, 16'h8503, 16'h8b01, 16'h8c93, 16'h9101, 16'h8300, 16'h3eb0, 16'h3f03,
		16'h4010, 16'h4213, 16'h4346, 16'h4423, 16'h4576, 16'h4600, 16'h475e, 16'h484f,
		16'h4940, 16'h1791, 16'h2bf9, 16'h000a, 16'h1b14, 16'h1a11, 16'h1c06, 16'h1f42,
		16'h0014, 16'h190a, 16'h191a, 16'h0028, 16'h1912, 16'h0028, 16'h1e27, 16'h0064,
		16'h2460, 16'h3d40, 16'h3438, 16'h3538, 16'h2438, 16'h0028, 16'h243c, 16'h161c,
		16'h0106, 16'h5500, 16'h0200, 16'h0300, 16'h0400, 16'h05ef, 16'h0600, 16'h0700,
		16'h0801, 16'h098f
	};

	logic init_commands_clk;
	logic init_commands_reset;
	logic host_req;
	logic host_is_cmd;
	logic [7:0] host_reg;
	logic [15:0] host_data;
	logic host_ack;
	logic init_done;
	logic lcd_rst;
	logic lcd_cs;
	logic lcd_rs;
	logic lcd_wr;
	logic [15:0] lcd_db;

	bit host_cmd_q[$];
	logic [7:0] host_reg_q[$];
	logic [15:0] host_data_q[$];
	logic [16:0] cap_word_q[$]; // {rs, db}
	int cap_cycle_q[$];
	logic [1:0] cap_state_q[$]; // {init_done, host_ack}

	int cycle = 0;
	int rst_rise_cycle = 0;
	int cap_count = 0;
	int word_idx = 0;
	int prev_cycle = 0;
	int mismatch_errors = 0;
	int other_errors = 0;
	int timeout_errors = 0;
	logic last_wr = 1'b1;
	logic last_rst = 1'b0;
	logic last_init_done = 1'b0;
	logic [16:0] got_word;
	logic [16:0] exp_word;
	logic [1:0] got_state;
	int got_cycle;
	int gap_ms;
	logic [31:0] rng_state = 32'h186e0bc5;

	tb_clock_gen tb_clock_gen_i (
		.init_commands_clk(init_commands_clk),
		.init_commands_reset(init_commands_reset)
	);

	hx8352_controller hx8352_controller_i (
		.init_commands_clk(init_commands_clk),
		.init_commands_reset(init_commands_reset),
		.host_req(host_req),
		.host_is_cmd(host_is_cmd),
		.host_reg(host_reg),
		.host_data(host_data),
		.host_ack(host_ack),
		.init_done(init_done),
		.lcd_rst(lcd_rst),
		.lcd_cs(lcd_cs),
		.lcd_rs(lcd_rs),
		.lcd_wr(lcd_wr),
		.lcd_db(lcd_db)
	);

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// k-th register write of the table as {register, value}
	function automatic logic [15:0] table_write(input int k);
		int count;
		int i;
		table_write = 16'h0000;
		count = 0;
		for (i = 0; i < TABLE_LEN; i++) begin
			if (POWER_ON_TABLE[i][15:8] != 8'h00) begin
				if (count == k) table_write = POWER_ON_TABLE[i];
				count++;
			end
		end
	endfunction

	// Milliseconds of delay between write k-1 and write k
	function automatic int delay_before(input int k);
		int count;
		int ms;
		int i;
		count = 0;
		ms = 0;
		for (i = 0; i < TABLE_LEN; i++) begin
			if (POWER_ON_TABLE[i][15:8] == 8'h00) begin
				if (count == k) ms += int'(POWER_ON_TABLE[i][7:0]);
			end else begin
				count++;
			end
		end
		return ms;
	endfunction

	function automatic logic [16:0] expected_word(input int n);
		logic [15:0] entry;
		int h;
		if (n < INIT_WORDS) begin
			entry = table_write(n / 2);
			if (n % 2 == 0) return {1'b0, 8'h00, entry[15:8]};
			return {1'b1, 8'h00, entry[7:0]};
		end
		h = (n - INIT_WORDS) / 2;
		if (n % 2 == 0) return {1'b0, 8'h00, host_cmd_q[h] ? host_reg_q[h] : PIXEL_REG};
		return {1'b1, host_data_q[h]};
	endfunction

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatch_errors++;
		end
	endtask

	// Bus monitor on the falling edge
	always @(negedge init_commands_clk) begin
		cycle++;
		if (lcd_rst === 1'b1 && last_rst !== 1'b1) rst_rise_cycle = cycle;
		if (lcd_wr === 1'b0) begin
			assert (lcd_rst === 1'b1 && cycle - rst_rise_cycle >= RST_WAIT_CYCLES) else begin
				$display("Write strobe at %0t during panel reset or recovery", $time);
				other_errors++;
			end
		end
		if (lcd_wr === 1'b1 && last_wr === 1'b0 && lcd_cs === 1'b0) begin
			cap_word_q.push_back({lcd_rs, lcd_db});
			cap_cycle_q.push_back(cycle);
			cap_state_q.push_back({init_done, host_ack});
			cap_count++;
		end
		if (init_done === 1'b1 && last_init_done !== 1'b1) begin
			assert (cap_count == INIT_WORDS) else begin
				$display("init_done rose at %0t after %0d words instead of %0d", $time,
					cap_count, INIT_WORDS);
				other_errors++;
			end
		end
		last_wr = lcd_wr;
		last_rst = lcd_rst;
		last_init_done = init_done;
	end

	// Compare process
	always @(posedge init_commands_clk) begin
		while (cap_word_q.size() > 0) begin
			got_word = cap_word_q.pop_front();
			got_cycle = cap_cycle_q.pop_front();
			got_state = cap_state_q.pop_front();
			assert (word_idx < INIT_WORDS + 2 * host_data_q.size()) else begin
				$display("Unexpected write strobe at %0t, word %0d", $time, word_idx);
				other_errors++;
			end
			if (word_idx < INIT_WORDS + 2 * host_data_q.size()) begin
				exp_word = expected_word(word_idx);
				check_value("lcd_rs", {15'h0, got_word[16]}, {15'h0, exp_word[16]});
				check_value("lcd_db", got_word[15:0], exp_word[15:0]);
			end
			if (word_idx < INIT_WORDS && word_idx > 0 && word_idx % 2 == 0) begin
				gap_ms = delay_before(word_idx / 2);
				assert (got_cycle - prev_cycle >= gap_ms * CYCLES_PER_MS) else begin
					$display("Delay of %0d ms too short before word %0d: %0d cycles", gap_ms,
						word_idx, got_cycle - prev_cycle);
					other_errors++;
				end
			end
			assert (got_state[0] === 1'b0) else begin
				$display("Write strobe at %0t while host_ack was high", $time);
				other_errors++;
			end
			if (word_idx < INIT_WORDS) check_value("init_done", {15'h0, got_state[1]}, 16'h0);
			prev_cycle = got_cycle;
			word_idx++;
		end
	end

	task automatic host_write(input bit is_cmd, input int timeout, output bit ok);
		int t;
		int expected_count;
		ok = 1'b0;
		rng_state = next_random(rng_state);
		host_cmd_q.push_back(is_cmd);
		host_reg_q.push_back(rng_state[7:0]);
		host_data_q.push_back(rng_state[23:8]);
		expected_count = INIT_WORDS + 2 * host_data_q.size();
		@(negedge init_commands_clk);
		host_req = 1'b1;
		host_is_cmd = is_cmd;
		host_reg = rng_state[7:0];
		host_data = rng_state[23:8];
		t = 0;
		while (host_ack !== 1'b1 && t < timeout) begin
			@(negedge init_commands_clk);
			t++;
		end
		if (host_ack !== 1'b1) begin
			$display("Timeout at %0t waiting for host_ack to rise", $time);
			timeout_errors++;
			return;
		end
		check_value("init_done", {15'h0, init_done}, 16'h1);
		assert (cap_count == expected_count) else begin
			$display("host_ack rose after %0d words, expected %0d", cap_count, expected_count);
			other_errors++;
		end
		repeat (HOLD_CYCLES) begin // Request held past the ack
			@(negedge init_commands_clk);
			check_value("host_ack", {15'h0, host_ack}, 16'h1);
		end
		assert (cap_count == expected_count) else begin
			$display("Write strobe at %0t while the request was held", $time);
			other_errors++;
		end
		host_req = 1'b0;
		t = 0;
		while (host_ack !== 1'b0 && t < XFER_TIMEOUT) begin
			@(negedge init_commands_clk);
			t++;
		end
		if (host_ack !== 1'b0) begin
			$display("Timeout at %0t waiting for host_ack to fall", $time);
			timeout_errors++;
			return;
		end
		ok = 1'b1;
	endtask

	task automatic run_tests();
		bit ok;
		int i;
		int t;
		repeat (5) @(negedge init_commands_clk);
		check_value("lcd_rst", {15'h0, lcd_rst}, 16'h0);
		check_value("lcd_cs", {15'h0, lcd_cs}, 16'h1);
		check_value("lcd_wr", {15'h0, lcd_wr}, 16'h1);
		check_value("lcd_rs", {15'h0, lcd_rs}, 16'h0);
		check_value("lcd_db", lcd_db, 16'h0);
		check_value("host_ack", {15'h0, host_ack}, 16'h0);
		check_value("init_done", {15'h0, init_done}, 16'h0);
		t = 0;
		while (init_commands_reset !== 1'b0 && t < 100) begin
			@(negedge init_commands_clk);
			t++;
		end
		if (init_commands_reset !== 1'b0) begin
			$display("Timeout at %0t waiting for reset release", $time);
			timeout_errors++;
			return;
		end
		host_write(1'b1, INIT_TIMEOUT, ok); // Held until power-on ends
		if (!ok) return;
		for (i = 0; i < 12; i++) begin
			host_write(i < 4 ? 1'b1 : (i < 8 ? 1'b0 : rng_state[31]), XFER_TIMEOUT, ok);
			if (!ok) return;
		end
		repeat (20) @(negedge init_commands_clk);
		assert (word_idx == cap_count && cap_count == INIT_WORDS + 2 * host_data_q.size())
		else begin
			$display("Word count off: %0d captured, %0d compared", cap_count, word_idx);
			other_errors++;
		end
	endtask

	task automatic finish_run();
		$display("Errors: %0d mismatches, %0d other, %0d timeouts", mismatch_errors,
			other_errors, timeout_errors);
		if (mismatch_errors + other_errors + timeout_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	initial begin
		host_req = 1'b0;
		host_is_cmd = 1'b0;
		host_reg = 8'h00;
		host_data = 16'h0000;
		run_tests();
		finish_run();
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/lcd_pkg.sv
hw/lcd_write_if.sv
hw/lcd_reset_gen.sv
hw/lcd_delay_timer.sv
hw/lcd_init_rom.sv
hw/lcd_bus_writer.sv
hw/lcd_sequencer.sv
hw/hx8352_controller.sv
sim/tb_clock_gen.sv
sim/hx8352_controller_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator, result taken from the log
LOG=sim.log
rm -f "$LOG"
verilator --binary --assert -Wno-fatal --top-module hx8352_controller_tb \
	-f verilog.f -o hx8352_sim > "$LOG" 2>&1 &&
	./obj_dir/hx8352_sim >> "$LOG" 2>&1 ||
	echo "TEST FAIL" >> "$LOG"
cat "$LOG"
if grep -q "TEST FAIL" "$LOG"; then
	exit 1
fi
exit 0
